/* sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    localparam int SD_FRAME_BITS = 48;     // Start, dir, index, arg, CRC7, end

    typedef logic [5:0] sd_cmd_idx_t;

    // Command indices served by the card model
    localparam sd_cmd_idx_t CMD_GO_IDLE          = 6'd0;
    localparam sd_cmd_idx_t CMD_SEND_IF_COND     = 6'd8;
    localparam sd_cmd_idx_t CMD_SEND_STATUS      = 6'd13;
    localparam sd_cmd_idx_t CMD_APP_CMD          = 6'd55;
    localparam sd_cmd_idx_t ACMD_SD_SEND_OP_COND = 6'd41;

    typedef enum logic [1:0] {
        RESP_NONE,                         // No response on the line
        RESP_R1,                           // Card status
        RESP_R3,                           // OCR, index and CRC sent as ones
        RESP_R7                            // Interface condition echo
    } sd_resp_kind_t;

    typedef struct packed {
        sd_cmd_idx_t cmd;
        logic [31:0] arg;
        logic        crc_err;              // Received CRC7 did not match
    } sd_req_t;

    typedef struct packed {
        sd_resp_kind_t kind;
        sd_cmd_idx_t   index;
        logic [31:0]   payload;
    } sd_resp_t;

    // R1 card status bits
    localparam int ST_COM_CRC_ERROR   = 23;
    localparam int ST_ILLEGAL_COMMAND = 22;
    localparam int ST_STATE_LSB       = 9;  // current_state[3:0] starts here
    localparam int ST_APP_CMD         = 5;

    localparam int OCR_BUSY_BIT = 31;      // Set once power-up has completed

endpackage

`default_nettype wire

/* sd_cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Decoded host command from the receiver to the card model
interface sd_req_if;
    import sd_cmd_pkg::*;

    logic    valid;    // One-cycle strobe per accepted frame
    sd_req_t req;
    logic    listen;   // Line is free, receiver may look for a start bit

    modport rx_mp (
        output valid,
        output req,
        input  listen
    );

    modport exec_mp (
        input valid,
        input req
    );
endinterface

// Response to be serialized by the transmitter
interface sd_resp_if;
    import sd_cmd_pkg::*;

    logic     valid;   // One-cycle strobe
    sd_resp_t resp;
    logic     busy;    // Transmitter owns the line

    modport exec_mp (
        output valid,
        output resp,
        input  busy
    );

    modport tx_mp (
        input  valid,
        input  resp,
        output busy
    );
endinterface

`default_nettype wire

/* sd_crc7.sv */
`timescale 1ns/1ns
`default_nettype none

// Serial CRC7, polynomial x^7 + x^3 + 1
module sd_crc7 (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_next,
    input  logic       i_dat,
    output logic [6:0] o_crc7
);

    logic [6:0] crc;
    logic       fb;

    assign fb = i_dat ^ crc[6];    // Feedback into taps 0 and 3

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc <= '0;
        end else if (i_clear) begin
            crc <= '0;
        end else if (i_next) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

    assign o_crc7 = crc;

endmodule

`default_nettype wire

/* sd_cmd_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_rx #(
    parameter int P_INIT_CLKS = 74
) (
    input  logic    i_clk,
    input  logic    i_nrst,
    input  logic    i_cmd,
    output logic    o_busy,
    sd_req_if.rx_mp req
);
    import sd_cmd_pkg::*;

    localparam int CNT_W = $clog2(P_INIT_CLKS + 1);

    typedef enum logic [1:0] {
        RX_INIT,       // Power-up clocks
        RX_IDLE,       // Looking for a start bit
        RX_RECV        // Shifting in the frame
    } rx_state_t;

    rx_state_t                state;
    logic [CNT_W-1:0]         init_cnt;
    logic [5:0]               bit_cnt;      // Position of the bit sampled this cycle
    logic [SD_FRAME_BITS-3:0] shift;        // Last 46 line samples
    logic                     crc_clear;
    logic                     crc_next;
    logic [6:0]               crc_calc;
    logic                     frame_end;

    sd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (i_cmd),
        .o_crc7  (crc_calc)
    );

    // Start bit is zero and leaves the CRC unchanged, so only bits 1..39 are fed
    assign crc_clear = (state != RX_RECV);
    assign crc_next  = (state == RX_RECV) && (bit_cnt < 6'd40);
    assign frame_end = (state == RX_RECV) && (bit_cnt == 6'(SD_FRAME_BITS - 1));
    assign o_busy    = (state == RX_INIT);

    always_ff @(posedge i_clk) begin
        shift <= {shift[SD_FRAME_BITS-4:0], i_cmd};
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= RX_INIT;
            init_cnt  <= '0;
            bit_cnt   <= '0;
            req.valid <= 1'b0;
        end else begin
            req.valid <= 1'b0;
            case (state)
                RX_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == CNT_W'(P_INIT_CLKS - 1)) begin
                        state <= RX_IDLE;
                    end
                end
                RX_IDLE: begin
                    if (req.listen && !i_cmd) begin
                        state   <= RX_RECV;
                        bit_cnt <= 6'd1;
                    end
                end
                RX_RECV: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (frame_end) begin
                        state     <= RX_IDLE;
                        req.valid <= shift[45];     // Host frames only, dir bit 1
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // At the end bit, shift[45] holds the transmission bit and shift[0] the last CRC bit
    always_ff @(posedge i_clk) begin
        if (frame_end) begin
            req.req.cmd     <= shift[44:39];
            req.req.arg     <= shift[38:7];
            req.req.crc_err <= (crc_calc != shift[6:0]);
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_exec #(
    parameter logic [23:0] P_OCR = 24'hFF8000
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    sd_req_if.exec_mp   req,
    sd_resp_if.exec_mp  resp
);
    import sd_cmd_pkg::*;

    logic          card_ready;     // current_state ready, else idle
    logic          app_cmd;        // Previous command was CMD55
    logic          crc_err_flag;
    logic          illegal_flag;
    logic          acmd41_seen;
    logic          is_acmd41;
    logic          resp_fire;
    sd_resp_kind_t kind;
    logic [31:0]   status;
    logic [31:0]   payload;

    assign is_acmd41 = app_cmd && (req.req.cmd == ACMD_SD_SEND_OP_COND);
    assign resp_fire = (kind != RESP_NONE) && !resp.busy;

    // R1 card status from the current model state
    always_comb begin
        status                     = '0;
        status[ST_COM_CRC_ERROR]   = crc_err_flag;
        status[ST_ILLEGAL_COMMAND] = illegal_flag;
        status[ST_STATE_LSB +: 4]  = {3'b000, card_ready};
        status[ST_APP_CMD]         = app_cmd || (req.req.cmd == CMD_APP_CMD);
    end

    always_comb begin
        kind    = RESP_NONE;
        payload = status;
        if (!req.req.crc_err) begin
            if (is_acmd41) begin
                kind                  = RESP_R3;
                payload               = {8'h00, P_OCR};
                payload[OCR_BUSY_BIT] = acmd41_seen;    // Second ACMD41 completes power-up
            end else begin
                case (req.req.cmd)
                    CMD_SEND_IF_COND: begin
                        kind    = RESP_R7;
                        payload = {20'h00000, req.req.arg[11:0]};  // Voltage and pattern echo
                    end
                    CMD_SEND_STATUS,
                    CMD_APP_CMD:      kind = RESP_R1;
                    default:          kind = RESP_NONE;   // CMD0 and unknown commands
                endcase
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            card_ready   <= 1'b0;
            app_cmd      <= 1'b0;
            crc_err_flag <= 1'b0;
            illegal_flag <= 1'b0;
            acmd41_seen  <= 1'b0;
            resp.valid   <= 1'b0;
        end else begin
            resp.valid <= 1'b0;
            if (req.valid) begin
                resp.valid <= resp_fire;
                app_cmd    <= 1'b0;     // ACMD window is one command long
                if (req.req.crc_err) begin
                    crc_err_flag <= 1'b1;
                end else if (is_acmd41) begin
                    acmd41_seen <= 1'b1;
                    if (acmd41_seen) begin
                        card_ready <= 1'b1;
                    end
                end else begin
                    case (req.req.cmd)
                        CMD_GO_IDLE: begin
                            card_ready   <= 1'b0;
                            crc_err_flag <= 1'b0;
                            illegal_flag <= 1'b0;
                            acmd41_seen  <= 1'b0;
                        end
                        CMD_APP_CMD:      app_cmd <= 1'b1;
                        CMD_SEND_IF_COND,
                        CMD_SEND_STATUS:  ;
                        default:          illegal_flag <= 1'b1;
                    endcase
                end
                // Error bits are clear-on-read
                if ((kind == RESP_R1) && resp_fire) begin
                    crc_err_flag <= 1'b0;
                    illegal_flag <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req.valid) begin
            resp.resp.kind    <= kind;
            resp.resp.index   <= req.req.cmd;
            resp.resp.payload <= payload;
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_tx (
    input  logic     i_clk,
    input  logic     i_nrst,
    output logic     o_cmd,
    output logic     o_cmd_dir,
    sd_resp_if.tx_mp resp,
    output logic     o_listen
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,       // Line released to the host
        TX_TURN,       // Turnaround cycle, card drives 1
        TX_SEND        // 48 frame bits
    } tx_state_t;

    tx_state_t                state;
    logic [5:0]               bit_cnt;
    logic [SD_FRAME_BITS-1:0] shift;       // MSB is on the line
    logic                     is_r3;
    logic                     start;
    sd_cmd_idx_t              frame_idx;
    logic                     crc_clear;
    logic                     crc_next;
    logic                     crc_dat;
    logic [6:0]               crc_calc;

    sd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc_calc)
    );

    assign start     = (state == TX_IDLE) && resp.valid;
    assign frame_idx = (resp.resp.kind == RESP_R3) ? '1 : resp.resp.index;

    // CRC runs one bit ahead of the line so it is complete when bit 39 leaves
    assign crc_clear = (state == TX_IDLE);
    assign crc_next  = (state == TX_TURN) || ((state == TX_SEND) && (bit_cnt < 6'd39));
    assign crc_dat   = (state == TX_TURN) ? shift[SD_FRAME_BITS-1] : shift[SD_FRAME_BITS-2];

    always_ff @(posedge i_clk) begin
        if (start) begin
            shift <= {2'b00, frame_idx, resp.resp.payload, 8'hFF};
            is_r3 <= (resp.resp.kind == RESP_R3);
        end else if (state == TX_SEND) begin
            if (bit_cnt == 6'd39) begin
                shift <= {(is_r3 ? 7'h7F : crc_calc), {(SD_FRAME_BITS - 7){1'b1}}};
            end else begin
                shift <= {shift[SD_FRAME_BITS-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: if (start) state <= TX_TURN;
                TX_TURN: begin
                    state   <= TX_SEND;
                    bit_cnt <= '0;
                end
                TX_SEND: begin
                    if (bit_cnt == 6'(SD_FRAME_BITS - 1)) begin
                        state <= TX_IDLE;    // End bit was on the line
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign o_cmd     = (state == TX_SEND) ? shift[SD_FRAME_BITS-1] : 1'b1;
    assign o_cmd_dir = (state == TX_IDLE);
    assign resp.busy = (state != TX_IDLE);
    assign o_listen  = (state == TX_IDLE);

endmodule

`default_nettype wire

/* sd_cmd_top.sv */
`timescale 1ns/1ns
`default_nettype none

// Card side of the SD command line, host-facing pins only
module sd_cmd_top #(
    parameter int          P_INIT_CLKS = 74,
    parameter logic [23:0] P_OCR       = 24'hFF8000
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_cmd,       // Line level from the host
    output logic o_cmd,       // Card line value
    output logic o_cmd_dir,   // 1 listening, 0 driving
    output logic o_busy       // Power-up wait
);

    sd_req_if  req_if ();
    sd_resp_if resp_if ();

    sd_cmd_rx #(
        .P_INIT_CLKS (P_INIT_CLKS)
    ) u_rx (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_cmd  (i_cmd),
        .o_busy (o_busy),
        .req    (req_if.rx_mp)
    );

    sd_cmd_exec #(
        .P_OCR (P_OCR)
    ) u_exec (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .req    (req_if.exec_mp),
        .resp   (resp_if.exec_mp)
    );

    sd_cmd_tx u_tx (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .o_cmd     (o_cmd),
        .o_cmd_dir (o_cmd_dir),
        .resp      (resp_if.tx_mp),
        .o_listen  (req_if.listen)
    );

endmodule

`default_nettype wire

/* tb_sd_cmd_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

// Line protocol checks on the card side of the command line
module tb_sd_cmd_asserts (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire logic i_cmd_line,     // Card line value
    input wire logic i_cmd_dir,
    input wire logic i_req_valid,
    input wire logic i_resp_valid
);

    logic [6:0] low_cnt;     // Cycles with the card driving
    int         fail_cnt = 0;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            low_cnt <= '0;
        end else if (!i_cmd_dir) begin
            low_cnt <= low_cnt + 1'b1;
        end else begin
            low_cnt <= '0;
        end
    end

    a_line_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cmd_dir |-> i_cmd_line)
        else begin
            fail_cnt++;
            $error("card line is low while the card listens");
        end

    // Turnaround, 48 frame bits, then release
    a_drive_length: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_cmd_dir) |-> (low_cnt == 7'd49))
        else begin
            fail_cnt++;
            $error("card drove the line for %0d cycles", low_cnt);
        end

    a_req_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |=> !i_req_valid)
        else begin
            fail_cnt++;
            $error("request strobe longer than one cycle");
        end

    a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |=> !i_resp_valid)
        else begin
            fail_cnt++;
            $error("response strobe longer than one cycle");
        end

endmodule

bind sd_cmd_top tb_sd_cmd_asserts u_asserts (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_cmd_line   (o_cmd),
    .i_cmd_dir    (o_cmd_dir),
    .i_req_valid  (req_if.valid),
    .i_resp_valid (resp_if.valid)
);

`default_nettype wire

/* tb_sd_cmd.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sd_cmd;
    import sd_cmd_pkg::*;

    localparam int          P_INIT_CLKS = 74;
    localparam logic [23:0] P_OCR       = 24'hFF8000;
    localparam int          RESP_WAIT   = 20;    // Cycles allowed before a start bit
    localparam int          QUIET_WAIT  = 100;
    localparam int          LINE_WAIT   = 100;

    logic i_clk;
    logic i_nrst;
    logic i_cmd;
    wire  o_cmd;
    wire  o_cmd_dir;
    wire  o_busy;

    int     errors = 0;
    int     checks = 0;
    integer seed   = 35;

    sd_cmd_top #(
        .P_INIT_CLKS (P_INIT_CLKS),
        .P_OCR       (P_OCR)
    ) dut (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_cmd     (i_cmd),
        .o_cmd     (o_cmd),
        .o_cmd_dir (o_cmd_dir),
        .o_busy    (o_busy)
    );

    always #10 i_clk = ~i_clk;

    // Whole run is far below this
    initial begin
        #1_000_000;
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    task automatic check_idx(input string name, input sd_cmd_idx_t got, input sd_cmd_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_kind_crc(input string name, input logic [6:0] got, input logic [6:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // CRC7 with x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    function automatic logic [31:0] r1_status(input logic crc_err, input logic illegal,
                                              input logic ready, input logic app);
        logic [31:0] st;
        st                     = '0;
        st[ST_COM_CRC_ERROR]   = crc_err;
        st[ST_ILLEGAL_COMMAND] = illegal;
        st[ST_STATE_LSB]       = ready;    // current_state 1 is ready
        st[ST_APP_CMD]         = app;
        return st;
    endfunction

    task automatic wait_listen();
        int n;
        n = 0;
        while (!o_cmd_dir && n < LINE_WAIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_cmd_dir) begin
            errors++;
            $display("card did not release the line within %0d cycles", LINE_WAIT);
        end
    endtask

    // Returns right after the DUT samples the end bit
    task automatic send_cmd(input sd_cmd_idx_t idx, input logic [31:0] arg, input logic bad_crc);
        logic [47:0] frame;
        logic [6:0]  crc;
        crc = crc7_of({2'b01, idx, arg});
        if (bad_crc) begin
            crc = crc ^ 7'h01;
        end
        frame = {2'b01, idx, arg, crc, 1'b1};
        wait_listen();
        for (int i = 47; i >= 0; i--) begin
            @(posedge i_clk);
            #2;
            i_cmd = frame[i];
        end
        @(posedge i_clk);
        #2;
        i_cmd = 1'b1;
    endtask

    task automatic get_resp(output logic [47:0] frame, output int latency, output logic got);
        int n;
        n     = 0;
        got   = 1'b0;
        frame = '1;
        while (!got && n < RESP_WAIT) begin
            @(negedge i_clk);
            n++;
            got = !o_cmd_dir && !o_cmd;
        end
        latency = n;
        if (!got) begin
            errors++;
            $display("no response start bit within %0d cycles at %0t ns", RESP_WAIT, $time);
        end else begin
            frame[47] = 1'b0;
            for (int i = 46; i >= 0; i--) begin
                @(negedge i_clk);
                frame[i] = o_cmd;
            end
            @(negedge i_clk);
            check_bit("o_cmd_dir after end bit", o_cmd_dir, 1'b1);
        end
    endtask

    task automatic expect_resp(input sd_cmd_idx_t exp_idx, input logic [31:0] exp_payload,
                               input logic is_r3);
        logic [47:0] frame;
        int          latency;
        logic        got;
        sd_cmd_idx_t idx;
        logic [6:0]  crc;
        idx = is_r3 ? 6'h3F : exp_idx;    // R3 sends index and CRC as ones
        crc = is_r3 ? 7'h7F : crc7_of({2'b00, idx, exp_payload});
        get_resp(frame, latency, got);
        if (got) begin
            check_word("start bit latency", 32'(latency), 32'd4);
            check_bit("transmission bit", frame[46], 1'b0);
            check_idx("response index", frame[45:40], idx);
            check_word("response payload", frame[39:8], exp_payload);
            check_kind_crc("response crc7", frame[7:1], crc);
            check_bit("end bit", frame[0], 1'b1);
        end
    endtask

    task automatic expect_no_resp();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < QUIET_WAIT) begin
            @(negedge i_clk);
            n++;
            seen = !o_cmd_dir;
        end
        if (seen) begin
            errors++;
            $display("card answered at %0t ns where no response was expected", $time);
            wait_listen();
        end
    endtask

    task automatic test_power_up();
        int n;
        n = 0;
        repeat (4) @(posedge i_clk);
        #2;
        check_bit("o_busy in reset", o_busy, 1'b1);
        check_bit("o_cmd_dir in reset", o_cmd_dir, 1'b1);
        check_bit("o_cmd in reset", o_cmd, 1'b1);
        i_nrst = 1'b1;
        while (o_busy && n < P_INIT_CLKS + 20) begin
            @(posedge i_clk);
            #1;
            n++;
        end
        if (o_busy) begin
            errors++;
            $display("o_busy still high %0d cycles after reset", n);
        end else begin
            check_word("power-up cycles", 32'(n), 32'(P_INIT_CLKS));
        end
        send_cmd(CMD_GO_IDLE, 32'h0, 1'b0);
        expect_no_resp();
    endtask

    task automatic test_if_cond();
        logic [31:0] arg;
        repeat (4) begin
            arg = $random(seed);
            send_cmd(CMD_SEND_IF_COND, arg, 1'b0);
            expect_resp(CMD_SEND_IF_COND, {20'h0, arg[11:0]}, 1'b0);
        end
    endtask

    // Busy bit clear on the first ACMD41, set on the second
    task automatic test_op_cond();
        send_cmd(CMD_APP_CMD, 32'h0, 1'b0);
        expect_resp(CMD_APP_CMD, r1_status(1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        send_cmd(ACMD_SD_SEND_OP_COND, 32'h40FF8000, 1'b0);
        expect_resp(ACMD_SD_SEND_OP_COND, {8'h00, P_OCR}, 1'b1);
        send_cmd(CMD_APP_CMD, 32'h0, 1'b0);
        expect_resp(CMD_APP_CMD, r1_status(1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        send_cmd(ACMD_SD_SEND_OP_COND, 32'h40FF8000, 1'b0);
        expect_resp(ACMD_SD_SEND_OP_COND, {8'h80, P_OCR}, 1'b1);
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b0);
        expect_resp(CMD_SEND_STATUS, r1_status(1'b0, 1'b0, 1'b1, 1'b0), 1'b0);
    endtask

    task automatic test_crc_error();
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b1);
        expect_no_resp();
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b0);
        expect_resp(CMD_SEND_STATUS, r1_status(1'b1, 1'b0, 1'b1, 1'b0), 1'b0);
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b0);
        expect_resp(CMD_SEND_STATUS, r1_status(1'b0, 1'b0, 1'b1, 1'b0), 1'b0);
    endtask

    task automatic test_illegal_cmd();
        send_cmd(6'd6, 32'h0, 1'b0);
        expect_no_resp();
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b0);
        expect_resp(CMD_SEND_STATUS, r1_status(1'b0, 1'b1, 1'b1, 1'b0), 1'b0);
        send_cmd(CMD_APP_CMD, 32'h00010000, 1'b0);
        expect_resp(CMD_APP_CMD, r1_status(1'b0, 1'b0, 1'b1, 1'b1), 1'b0);
        send_cmd(CMD_SEND_STATUS, 32'h00010000, 1'b0);
        expect_resp(CMD_SEND_STATUS, r1_status(1'b0, 1'b0, 1'b1, 1'b1), 1'b0);
    endtask

    initial begin
        i_clk  = 1'b0;
        i_nrst = 1'b0;
        i_cmd  = 1'b1;    // Host line idles high
        test_power_up();
        test_if_cond();
        test_op_cond();
        test_crc_error();
        test_illegal_cmd();
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut.u_asserts.fail_cnt);
        if (errors == 0 && dut.u_asserts.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
sd_cmd_pkg.sv
sd_cmd_if.sv
sd_crc7.sv
sd_cmd_rx.sv
sd_cmd_exec.sv
sd_cmd_tx.sv
sd_cmd_top.sv
tb_sd_cmd_asserts.sv
tb_sd_cmd.sv

/* Makefile */
TOP := tb_sd_cmd

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
